// File: include/adc_settings.svh
`ifndef ADC_SETTINGS_SVH
`define ADC_SETTINGS_SVH

// --------------------
// SPI byte and command encodings
// --------------------
`define ADC_BYTE_W        8

// Direct commands, sent as the full byte
`define ADC_OP_RDATA      8'h01
`define ADC_OP_SELFCAL    8'hF0

// Register commands, upper nibble of the first byte
`define ADC_PREFIX_RREG   4'h1
`define ADC_PREFIX_WREG   4'h5

// Low 16 bits of a host word that carries a direct command
`define ADC_DIRECT_MARK   16'hFFFF

// Clocked out on DIN while a byte is read back
`define ADC_DUMMY_BYTE    8'h00

// --------------------
// Datasheet gaps in clock cycles
// --------------------
`define ADC_TIMER_W       10
`define ADC_T6_CYCLES     700
`define ADC_T10_CYCLES    110

`endif

// File: logic/adc_pkg.sv
`include "adc_settings.svh"

package adc_pkg;

  // Host command word as {opcode, count, data}
  typedef struct packed {
    logic [`ADC_BYTE_W-1:0] op_byte;
    logic [`ADC_BYTE_W-1:0] count_byte;
    logic [`ADC_BYTE_W-1:0] data_byte;
  } adc_cmd_t;

  // Decoded operation
  typedef enum logic [2:0] {
    OP_NONE,
    OP_RDATA,
    OP_SELFCAL,
    OP_RREG,
    OP_WREG,
    OP_ILLEGAL
  } adc_op_e;

  // Request to the byte-wide SPI master
  typedef struct packed {
    logic                   start;
    logic [`ADC_BYTE_W-1:0] tx_byte;
  } spi_req_t;

  // Result register load strobe
  // Slot 0 holds the register read, slots 1 to 3 hold MSB, mid and LSB
  typedef struct packed {
    logic       load;
    logic [1:0] slot;
  } read_load_t;

endpackage

// File: logic/adc_cmd_decoder.sv
`timescale 1ns/1ps
`include "adc_settings.svh"

module adc_cmd_decoder
  import adc_pkg::*;
(
  input  adc_cmd_t cmd_i,
  output adc_op_e  op_o
);

  logic direct_cmd;
  logic single_count;

  // A direct command is marked by all ones in count and data
  assign direct_cmd   = ({cmd_i.count_byte, cmd_i.data_byte} == `ADC_DIRECT_MARK);

  // Register access is limited to one byte per command
  assign single_count = (cmd_i.count_byte == '0);

  always_comb begin
    op_o = OP_ILLEGAL;
    if (direct_cmd) begin
      case (cmd_i.op_byte)
        `ADC_OP_SELFCAL: op_o = OP_SELFCAL;
        `ADC_OP_RDATA:   op_o = OP_RDATA;
        // RDATAC, SDATAC and everything else land here
        default:         op_o = OP_ILLEGAL;
      endcase
    end else if (single_count) begin
      case (cmd_i.op_byte[`ADC_BYTE_W-1:4])
        `ADC_PREFIX_RREG: op_o = OP_RREG;
        `ADC_PREFIX_WREG: op_o = OP_WREG;
        default:          op_o = OP_ILLEGAL;
      endcase
    end
  end

endmodule

// File: logic/adc_delay_timer.sv
`timescale 1ns/1ps
`include "adc_settings.svh"

module adc_delay_timer #(
  parameter int unsigned DELAY_CYCLES = 16
) (
  input  logic clock_i,
  input  logic reset_i,
  input  logic clear_i,
  input  logic enable_i,
  output logic done_o
);

  localparam int unsigned TIMER_W = `ADC_TIMER_W;
  localparam logic [TIMER_W-1:0] TERMINAL = TIMER_W'(DELAY_CYCLES);

  logic [TIMER_W-1:0] count_q;

  // Clear wins over enable; the count parks at its terminal value
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (enable_i && !done_o) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign done_o = (count_q == TERMINAL);

endmodule

// File: logic/adc_seq_fsm.sv
`timescale 1ns/1ps
`include "adc_settings.svh"

module adc_seq_fsm
  import adc_pkg::*;
(
  input  logic       clock_i,
  input  logic       reset_i,
  input  logic       start_i,
  input  adc_cmd_t   cmd_i,
  input  adc_op_e    op_i,
  input  logic       drdy_n_i,
  input  logic       spi_done_i,
  input  logic       t6_done_i,
  input  logic       t10_done_i,
  output spi_req_t   spi_o,
  output read_load_t read_o,
  output logic       cs_n_o,
  output logic       t6_en_o,
  output logic       t6_clear_o,
  output logic       t10_en_o,
  output logic       t10_clear_o,
  output logic       done_o
);

  typedef enum logic [4:0] {
    IDLE,
    // RDATA
    RDATA_WAIT_DRDY,
    RDATA_CMD,
    RDATA_WAIT_T6,
    RDATA_READ_0,
    RDATA_READ_1,
    RDATA_READ_2,
    // RREG
    RREG_CMD,
    RREG_COUNT,
    RREG_WAIT_T6,
    RREG_READ,
    // WREG
    WREG_CMD,
    WREG_COUNT,
    WREG_DATA,
    // SELFCAL
    SELFCAL_CMD,
    SELFCAL_WAIT_DRDY,
    // Common tail
    WAIT_T10,
    DONE
  } seq_state_e;

  seq_state_e             state_q;
  seq_state_e             state_d;
  seq_state_e             first_state;
  adc_op_e                op_q;
  logic [`ADC_BYTE_W-1:0] wreg_data_q;
  logic                   accept;

  // New commands are taken only while idle or in the done cycle
  assign accept = start_i && (state_q == IDLE || state_q == DONE);

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // Command latch
  // --------------------
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      op_q <= OP_NONE;
    end else if (accept) begin
      op_q <= op_i;
    end
  end

  // Only the WREG payload is needed after acceptance
  always_ff @(posedge clock_i) begin
    if (accept) begin
      wreg_data_q <= cmd_i.data_byte;
    end
  end

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    case (op_i)
      OP_RDATA:   first_state = RDATA_WAIT_DRDY;
      OP_SELFCAL: first_state = SELFCAL_CMD;
      OP_RREG:    first_state = RREG_CMD;
      OP_WREG:    first_state = WREG_CMD;
      // Illegal commands leave the sequencer idle
      default:    first_state = IDLE;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE:        state_d = start_i ? first_state : IDLE;

      RDATA_WAIT_DRDY:   if (!drdy_n_i) state_d = RDATA_CMD;
      RDATA_CMD:         if (spi_done_i) state_d = RDATA_WAIT_T6;
      RDATA_WAIT_T6:     if (t6_done_i) state_d = RDATA_READ_0;
      RDATA_READ_0:      if (spi_done_i) state_d = RDATA_READ_1;
      RDATA_READ_1:      if (spi_done_i) state_d = RDATA_READ_2;
      RDATA_READ_2:      if (spi_done_i) state_d = WAIT_T10;

      RREG_CMD:          if (spi_done_i) state_d = RREG_COUNT;
      RREG_COUNT:        if (spi_done_i) state_d = RREG_WAIT_T6;
      RREG_WAIT_T6:      if (t6_done_i) state_d = RREG_READ;
      RREG_READ:         if (spi_done_i) state_d = WAIT_T10;

      WREG_CMD:          if (spi_done_i) state_d = WREG_COUNT;
      WREG_COUNT:        if (spi_done_i) state_d = WREG_DATA;
      WREG_DATA:         if (spi_done_i) state_d = WAIT_T10;

      SELFCAL_CMD:       if (spi_done_i) state_d = WAIT_T10;

      // Calibration is finished once DRDY falls again
      WAIT_T10: begin
        if (t10_done_i) begin
          state_d = (op_q == OP_SELFCAL) ? SELFCAL_WAIT_DRDY : DONE;
        end
      end
      SELFCAL_WAIT_DRDY: if (!drdy_n_i) state_d = DONE;

      default:           state_d = IDLE;
    endcase
  end

  // --------------------
  // Outputs
  // --------------------
  always_comb begin
    spi_o.start   = 1'b0;
    spi_o.tx_byte = `ADC_DUMMY_BYTE;
    read_o.load   = 1'b0;
    read_o.slot   = 2'd0;
    t6_en_o       = 1'b0;
    t6_clear_o    = 1'b0;
    t10_en_o      = 1'b0;
    t10_clear_o   = 1'b0;
    done_o        = 1'b0;

    case (state_q)
      IDLE, DONE: begin
        done_o = (state_q == DONE);
        // RDATA holds its first byte until DRDY
        if (start_i) begin
          case (op_i)
            OP_SELFCAL: begin
              spi_o.start   = 1'b1;
              spi_o.tx_byte = `ADC_OP_SELFCAL;
            end
            OP_RREG, OP_WREG: begin
              spi_o.start   = 1'b1;
              spi_o.tx_byte = cmd_i.op_byte;
            end
            default: ;
          endcase
        end
      end

      RDATA_WAIT_DRDY: begin
        if (!drdy_n_i) begin
          spi_o.start   = 1'b1;
          spi_o.tx_byte = `ADC_OP_RDATA;
        end
      end
      RDATA_CMD:      t6_clear_o = spi_done_i;
      RDATA_WAIT_T6: begin
        t6_en_o     = 1'b1;
        spi_o.start = t6_done_i;
      end
      RDATA_READ_0, RDATA_READ_1: begin
        // MSB then mid byte, each followed by the next dummy
        read_o.load = spi_done_i;
        read_o.slot = (state_q == RDATA_READ_0) ? 2'd1 : 2'd2;
        spi_o.start = spi_done_i;
      end
      RDATA_READ_2: begin
        read_o.load = spi_done_i;
        read_o.slot = 2'd3;
        t10_clear_o = spi_done_i;
      end

      RREG_CMD, WREG_CMD: begin
        // Count byte of zero, a single register
        spi_o.start   = spi_done_i;
        spi_o.tx_byte = 8'h00;
      end
      RREG_COUNT:     t6_clear_o = spi_done_i;
      RREG_WAIT_T6: begin
        t6_en_o     = 1'b1;
        spi_o.start = t6_done_i;
      end
      RREG_READ: begin
        read_o.load = spi_done_i;
        read_o.slot = 2'd0;
        t10_clear_o = spi_done_i;
      end

      WREG_COUNT: begin
        spi_o.start   = spi_done_i;
        spi_o.tx_byte = wreg_data_q;
      end
      WREG_DATA, SELFCAL_CMD: t10_clear_o = spi_done_i;

      WAIT_T10:       t10_en_o = 1'b1;

      default: ;
    endcase
  end

  // Chip select is low through the whole sequence and on the first byte
  assign cs_n_o = (state_q == IDLE || state_q == DONE || state_q == SELFCAL_WAIT_DRDY) ?
                  ~spi_o.start : 1'b0;

endmodule

// File: logic/adc_cmd_sequencer.sv
`timescale 1ns/1ps
`include "adc_settings.svh"

module adc_cmd_sequencer
  import adc_pkg::*;
(
  input  logic       clock_i,
  input  logic       reset_i,
  input  logic       start_i,
  input  adc_cmd_t   cmd_i,
  input  logic       drdy_n_i,
  input  logic       spi_done_i,
  output logic       done_o,
  output spi_req_t   spi_o,
  output logic       cs_n_o,
  output read_load_t read_o
);

  adc_op_e op;
  logic    t6_en;
  logic    t6_clear;
  logic    t6_done;
  logic    t10_en;
  logic    t10_clear;
  logic    t10_done;

  adc_cmd_decoder cmd_decoder (
    .cmd_i (cmd_i),
    .op_o  (op)
  );

  adc_seq_fsm seq_fsm (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .start_i     (start_i),
    .cmd_i       (cmd_i),
    .op_i        (op),
    .drdy_n_i    (drdy_n_i),
    .spi_done_i  (spi_done_i),
    .t6_done_i   (t6_done),
    .t10_done_i  (t10_done),
    .spi_o       (spi_o),
    .read_o      (read_o),
    .cs_n_o      (cs_n_o),
    .t6_en_o     (t6_en),
    .t6_clear_o  (t6_clear),
    .t10_en_o    (t10_en),
    .t10_clear_o (t10_clear),
    .done_o      (done_o)
  );

  // t6, DIN to DOUT gap before the read-back bytes
  adc_delay_timer #(.DELAY_CYCLES(`ADC_T6_CYCLES)) t6_timer (
    .clock_i  (clock_i),
    .reset_i  (reset_i),
    .clear_i  (t6_clear),
    .enable_i (t6_en),
    .done_o   (t6_done)
  );

  // t10, chip select hold after the last byte
  adc_delay_timer #(.DELAY_CYCLES(`ADC_T10_CYCLES)) t10_timer (
    .clock_i  (clock_i),
    .reset_i  (reset_i),
    .clear_i  (t10_clear),
    .enable_i (t10_en),
    .done_o   (t10_done)
  );

endmodule

// File: verif/adc_seq_checker.sv
`timescale 1ns/1ps
`include "adc_settings.svh"

module adc_seq_checker
  import adc_pkg::*;
(
  input  logic       clock_i,
  input  logic       reset_i,
  input  logic       start_i,
  input  adc_cmd_t   cmd_i,
  input  logic       drdy_n_i,
  input  logic       spi_done_i,
  input  logic       done_i,
  input  spi_req_t   spi_i,
  input  logic       cs_n_i,
  input  read_load_t read_i,
  output int         value_errors_o,
  output int         protocol_errors_o,
  output int         checked_o
);

  logic [`ADC_BYTE_W-1:0] exp_bytes[$];
  logic [`ADC_BYTE_W-1:0] got_bytes[$];
  logic [1:0]             exp_slots[$];
  logic [1:0]             got_slots[$];
  logic                   active = 1'b0;
  logic                   drdy_low_seen = 1'b0;
  int                     value_errors = 0;
  int                     protocol_errors = 0;
  int                     checked = 0;

  assign value_errors_o    = value_errors;
  assign protocol_errors_o = protocol_errors;
  assign checked_o         = checked;

  // Expected SPI bytes and result slots, straight from the decode rule
  function automatic logic build_expected(input adc_cmd_t cmd);
    exp_bytes.delete();
    exp_slots.delete();
    if ({cmd.count_byte, cmd.data_byte} == `ADC_DIRECT_MARK) begin
      if (cmd.op_byte == `ADC_OP_SELFCAL) begin
        exp_bytes.push_back(`ADC_OP_SELFCAL);
      end else if (cmd.op_byte == `ADC_OP_RDATA) begin
        exp_bytes = '{`ADC_OP_RDATA, `ADC_DUMMY_BYTE, `ADC_DUMMY_BYTE, `ADC_DUMMY_BYTE};
        exp_slots = '{2'd1, 2'd2, 2'd3};
      end
    end else if (cmd.count_byte == 8'h00) begin
      if (cmd.op_byte[7:4] == `ADC_PREFIX_RREG) begin
        exp_bytes = '{cmd.op_byte, 8'h00, `ADC_DUMMY_BYTE};
        exp_slots = '{2'd0};
      end else if (cmd.op_byte[7:4] == `ADC_PREFIX_WREG) begin
        exp_bytes = '{cmd.op_byte, 8'h00, cmd.data_byte};
      end
    end
    build_expected = (exp_bytes.size() != 0);
  endfunction

  task automatic compare_results();
    int i;
    if (got_bytes.size() != exp_bytes.size()) begin
      $display("Error: spi_o.start count expected %h got %h", exp_bytes.size(), got_bytes.size());
      value_errors++;
    end else begin
      for (i = 0; i < exp_bytes.size(); i++) begin
        if (got_bytes[i] != exp_bytes[i]) begin
          $display("Error: spi_o.tx_byte[%0d] expected %h got %h", i, exp_bytes[i], got_bytes[i]);
          value_errors++;
        end
      end
    end
    if (got_slots.size() != exp_slots.size()) begin
      $display("Error: read_o.load count expected %h got %h", exp_slots.size(), got_slots.size());
      value_errors++;
    end else begin
      for (i = 0; i < exp_slots.size(); i++) begin
        if (got_slots[i] != exp_slots[i]) begin
          $display("Error: read_o.slot[%0d] expected %h got %h", i, exp_slots[i], got_slots[i]);
          value_errors++;
        end
      end
    end
  endtask

  // Done is handled before a new start so that both can share a cycle
  always @(posedge clock_i) begin
    if (reset_i) begin
      active = 1'b0;
      if (!cs_n_i) begin
        $display("Error: cs_n_o expected 1 got 0 during reset");
        value_errors++;
      end
    end else begin
      if (done_i) begin
        if (!active) begin
          $display("done_o pulsed with no legal command in progress");
          protocol_errors++;
        end else begin
          if (exp_bytes.size() == 1 && !drdy_low_seen) begin
            $display("Calibration reported done before DRDY went low");
            protocol_errors++;
          end
          compare_results();
          checked++;
        end
        active = 1'b0;
        if (!cs_n_i) begin
          $display("Error: cs_n_o expected 1 got 0 in the done cycle");
          value_errors++;
        end
      end

      if (start_i) begin
        active = build_expected(cmd_i);
        got_bytes.delete();
        got_slots.delete();
      end

      if (spi_i.start) begin
        if (!active) begin
          $display("SPI start seen with no legal command in progress");
          protocol_errors++;
        end else if (exp_bytes[0] == `ADC_OP_RDATA && got_bytes.size() == 0 && drdy_n_i) begin
          $display("RDATA byte sent while DRDY was still high");
          protocol_errors++;
        end
        got_bytes.push_back(spi_i.tx_byte);
      end

      if (read_i.load) begin
        if (!active) begin
          $display("Result load seen with no legal command in progress");
          protocol_errors++;
        end
        got_slots.push_back(read_i.slot);
      end

      if ((spi_i.start || read_i.load) && cs_n_i) begin
        $display("Error: cs_n_o expected 0 got 1 during a transfer");
        value_errors++;
      end

      // DRDY must fall after the last byte of a calibration
      if (spi_done_i) begin
        drdy_low_seen = 1'b0;
      end else if (!drdy_n_i) begin
        drdy_low_seen = 1'b1;
      end
    end
  end

endmodule

// File: verif/tb_adc_cmd_sequencer.sv
`timescale 1ns/1ps
`include "adc_settings.svh"

module tb_adc_cmd_sequencer
  import adc_pkg::*;
();

  localparam int NUM_CMDS  = 15;
  localparam int NUM_LEGAL = NUM_CMDS - NUM_CMDS / 5;
  localparam int WATCHDOG_CYCLES = NUM_CMDS * (`ADC_T6_CYCLES + `ADC_T10_CYCLES + 100);

  logic        clock_i = 1'b0;
  logic        reset_i;
  logic        start_i;
  adc_cmd_t    cmd_i;
  logic        drdy_n_i = 1'b1;
  logic        spi_done_i = 1'b0;
  logic        done_o;
  spi_req_t    spi_o;
  logic        cs_n_o;
  read_load_t  read_o;
  int          seed = 32'h8764_246a;
  int          spi_wait = 0;
  int          drdy_wait = 0;
  int          drdy_len;
  logic        cal_busy = 1'b0;
  int          cmd_idx;
  int          value_errors;
  int          protocol_errors;
  int          checked;
  logic [31:0] rnd;

  always #4 clock_i = ~clock_i;

  adc_cmd_sequencer dut_i (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .start_i    (start_i),
    .cmd_i      (cmd_i),
    .drdy_n_i   (drdy_n_i),
    .spi_done_i (spi_done_i),
    .done_o     (done_o),
    .spi_o      (spi_o),
    .cs_n_o     (cs_n_o),
    .read_o     (read_o)
  );

  adc_seq_checker checker_i (
    .clock_i           (clock_i),
    .reset_i           (reset_i),
    .start_i           (start_i),
    .cmd_i             (cmd_i),
    .drdy_n_i          (drdy_n_i),
    .spi_done_i        (spi_done_i),
    .done_i            (done_o),
    .spi_i             (spi_o),
    .cs_n_i            (cs_n_o),
    .read_i            (read_o),
    .value_errors_o    (value_errors),
    .protocol_errors_o (protocol_errors),
    .checked_o         (checked)
  );

  // --------------------
  // SPI master and converter models
  // --------------------
  always @(posedge clock_i) begin
    spi_done_i <= 1'b0;
    if (reset_i) begin
      spi_wait  <= 0;
      drdy_wait <= 0;
      cal_busy  <= 1'b0;
      drdy_n_i  <= 1'b1;
    end else begin
      // Each byte finishes 2 to 9 cycles after its start
      if (spi_o.start) begin
        spi_wait <= 1 + ($unsigned($random(seed)) % 8);
      end else if (spi_wait != 0) begin
        spi_wait   <= spi_wait - 1;
        spi_done_i <= (spi_wait == 1);
      end

      // DRDY rises on every start and falls 0 to 40 cycles later
      if (start_i && cmd_i == {`ADC_OP_SELFCAL, `ADC_DIRECT_MARK}) begin
        // Calibration keeps DRDY high until chip select is released
        drdy_wait <= 0;
        drdy_n_i  <= 1'b1;
        cal_busy  <= 1'b1;
      end else if (start_i || (cal_busy && cs_n_o)) begin
        drdy_len = $unsigned($random(seed)) % 41;
        drdy_wait <= drdy_len;
        drdy_n_i  <= (drdy_len != 0);
        cal_busy  <= 1'b0;
      end else if (drdy_wait != 0) begin
        drdy_wait <= drdy_wait - 1;
        if (drdy_wait == 1) begin
          drdy_n_i <= 1'b0;
        end
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  // Nonzero count, unknown nibble, or a dropped continuous-read opcode
  function automatic adc_cmd_t illegal_cmd(input int variant, input logic [31:0] r);
    case (variant % 3)
      0:       illegal_cmd = {`ADC_PREFIX_RREG, r[3:0], r[15:8] | 8'h01, r[23:16]};
      1:       illegal_cmd = {(r[7:4] == `ADC_PREFIX_RREG || r[7:4] == `ADC_PREFIX_WREG) ?
                              4'hC : r[7:4], r[3:0], 8'h00, r[23:16]};
      default: illegal_cmd = {(r[0] ? 8'h03 : 8'h0F), `ADC_DIRECT_MARK};
    endcase
  endfunction

  task automatic send_cmd(input adc_cmd_t cmd, input logic legal);
    @(posedge clock_i);
    start_i <= 1'b1;
    cmd_i   <= cmd;
    @(posedge clock_i);
    start_i <= 1'b0;
    if (legal) begin
      @(negedge clock_i);
      while (!done_o) begin
        @(negedge clock_i);
      end
    end else begin
      // The sequencer should stay silent here
      repeat (50) @(posedge clock_i);
    end
  endtask

  initial begin
    reset_i = 1'b1;
    start_i = 1'b0;
    cmd_i   = '0;
    repeat (8) @(posedge clock_i);
    reset_i <= 1'b0;

    for (cmd_idx = 0; cmd_idx < NUM_CMDS; cmd_idx++) begin
      rnd = $random(seed);
      case (cmd_idx % 5)
        0:       send_cmd({`ADC_OP_RDATA, `ADC_DIRECT_MARK}, 1'b1);
        1:       send_cmd({`ADC_PREFIX_RREG, rnd[3:0], 8'h00, rnd[15:8]}, 1'b1);
        2:       send_cmd({`ADC_PREFIX_WREG, rnd[3:0], 8'h00, rnd[15:8]}, 1'b1);
        3:       send_cmd({`ADC_OP_SELFCAL, `ADC_DIRECT_MARK}, 1'b1);
        default: send_cmd(illegal_cmd(cmd_idx / 5, rnd), 1'b0);
      endcase
    end

    repeat (10) @(posedge clock_i);
    if (checked != NUM_LEGAL) begin
      $display("Only %0d of %0d legal commands reached a done", checked, NUM_LEGAL);
    end
    $display("Checked %0d commands, %0d value errors, %0d protocol errors",
             checked, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0 && checked == NUM_LEGAL) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock_i);
    $display("Timeout: the command series did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: project.f
+incdir+include
logic/adc_pkg.sv
logic/adc_cmd_decoder.sv
logic/adc_delay_timer.sv
logic/adc_seq_fsm.sv
logic/adc_cmd_sequencer.sv
verif/adc_seq_checker.sv
verif/tb_adc_cmd_sequencer.sv

// File: Makefile
TOP := tb_adc_cmd_sequencer

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module adc_cmd_sequencer
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
